//--- logic/cache_pkg.sv
package cache_pkg;

	// Address and data geometry
	localparam int addr_width = 16;
	localparam int word_width = 16;
	localparam int tag_width = 8;
	localparam int index_width = 5;
	localparam int offset_width = 3;

	// Cache and memory organisation
	localparam int num_lines = 32;
	localparam int words_per_line = 4;
	localparam int mem_latency = 2;	// Read strobe to data, in cycles
	localparam int mem_words = 32768;
	localparam int num_banks = 4;
	localparam int bank_rows = mem_words / num_banks;
	localparam int num_ports = 2;	// One per core

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [word_width-1:0] word_t;
	typedef logic [tag_width-1:0] tag_t;	// addr[15:8]
	typedef logic [index_width-1:0] index_t;	// addr[7:3]
	typedef logic [offset_width-1:0] offset_t;	// addr[2:0], even only

	typedef enum logic [3:0] {
		idle,
		comp_read,
		comp_write,
		wb_0,
		wb_1,
		wb_2,
		wb_3,
		req_0,
		req_1,
		req_2_fill_0,
		req_3_fill_1,
		fill_2,
		fill_3,
		finish,
		bad
	} ctrl_state_t;

endpackage

//--- logic/cache_array.sv
`timescale 1ns/1ns

module cache_array (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic comp,
	input  logic write,
	input  cache_pkg::index_t index,
	input  cache_pkg::tag_t tag,
	input  cache_pkg::offset_t offset,
	input  cache_pkg::word_t wdata,
	output logic hit,
	output logic valid,
	output logic dirty,
	output cache_pkg::tag_t victim_tag,
	output cache_pkg::word_t rdata
);

	cache_pkg::tag_t tag_mem [cache_pkg::num_lines];
	cache_pkg::word_t data_mem [cache_pkg::num_lines][cache_pkg::words_per_line];
	logic [cache_pkg::num_lines-1:0] valid_bits;
	logic [cache_pkg::num_lines-1:0] dirty_bits;
	logic [1:0] word_sel;
	logic comp_write;
	logic fill_write;

	assign word_sel = offset[2:1];	// Byte offset to word slot

	// Combinational lookup of the indexed line
	assign victim_tag = tag_mem[index];
	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];
	assign hit = valid_bits[index] && (tag_mem[index] == tag);
	assign rdata = data_mem[index][word_sel];

	// A compare write only lands on a hit
	assign comp_write = enable && write && comp && hit;
	assign fill_write = enable && write && !comp;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (comp_write) begin
			dirty_bits[index] <= 1'b1;	// Core store makes the line dirty
		end else if (fill_write) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= 1'b0;	// Line now matches memory
		end
	end

	always_ff @(posedge clk) begin
		if (comp_write || fill_write) begin
			data_mem[index][word_sel] <= wdata;
		end
		if (fill_write) begin
			tag_mem[index] <= tag;
		end
	end

endmodule

//--- logic/cache_controller.sv
`timescale 1ns/1ns

module cache_controller (
	input  logic clk,
	input  logic reset,
	input  logic rd,
	input  logic wr,
	input  cache_pkg::addr_t addr,
	input  cache_pkg::word_t wdata,
	output cache_pkg::word_t rdata,
	output logic done,
	output logic stall,
	output logic err,
	output logic arr_enable,
	output logic arr_comp,
	output logic arr_write,
	output cache_pkg::index_t arr_index,
	output cache_pkg::tag_t arr_tag,
	output cache_pkg::offset_t arr_offset,
	output cache_pkg::word_t arr_wdata,
	input  logic arr_hit,
	input  logic arr_valid,
	input  logic arr_dirty,
	input  cache_pkg::tag_t arr_victim_tag,
	input  cache_pkg::word_t arr_rdata,
	output logic mem_req,
	input  logic mem_grant,
	output logic mem_rd,
	output logic mem_wr,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata,
	input  cache_pkg::word_t mem_rdata
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t next_state;
	cache_pkg::addr_t req_addr;
	cache_pkg::word_t req_wdata;
	logic req_write;
	logic accept;
	logic in_compare;
	logic use_victim;
	cache_pkg::offset_t mem_offset;

	assign accept = (state == cache_pkg::idle) && (rd ^ wr);	// Exactly one strobe
	assign in_compare = (state == cache_pkg::comp_read) || (state == cache_pkg::comp_write);

	assign arr_index = req_addr[7:3];
	assign arr_tag = req_addr[15:8];	// Fill also writes the request tag

	// Victim line goes back under its stored tag
	assign mem_addr = {use_victim ? arr_victim_tag : req_addr[15:8], req_addr[7:3], mem_offset};
	assign mem_wdata = arr_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_pkg::idle;
			req_write <= 1'b0;
			mem_req <= 1'b0;
		end else begin
			state <= next_state;
			if (accept) begin
				req_write <= wr;
			end
			if (next_state == cache_pkg::finish || next_state == cache_pkg::idle) begin
				mem_req <= 1'b0;
			end else if (in_compare && !arr_hit) begin
				mem_req <= 1'b1;	// Hold until the retried compare hits
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr;
			req_wdata <= wdata;
		end
		if (state == cache_pkg::comp_read && arr_hit) begin
			rdata <= arr_rdata;	// Presented during finish
		end
	end

	always_comb begin
		next_state = state;
		done = 1'b0;
		stall = 1'b1;
		err = 1'b0;
		arr_enable = 1'b0;
		arr_comp = 1'b0;
		arr_write = 1'b0;
		arr_offset = req_addr[2:0];
		arr_wdata = req_wdata;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		mem_offset = 3'd0;
		use_victim = 1'b0;
		case (state)
			cache_pkg::idle: begin
				stall = 1'b0;
				if (accept) begin
					next_state = wr ? cache_pkg::comp_write : cache_pkg::comp_read;
				end
			end
			cache_pkg::comp_read, cache_pkg::comp_write: begin
				arr_enable = 1'b1;
				arr_comp = 1'b1;
				arr_write = (state == cache_pkg::comp_write);
				if (arr_hit) begin
					next_state = cache_pkg::finish;
				end else if (arr_valid && arr_dirty) begin
					next_state = cache_pkg::wb_0;	// Dirty victim first
				end else begin
					next_state = cache_pkg::req_0;
				end
			end
			cache_pkg::wb_0: begin
				arr_enable = 1'b1;
				arr_offset = 3'd0;
				use_victim = 1'b1;
				mem_wr = mem_grant;	// Wait here for the arbiter
				if (mem_grant) begin
					next_state = cache_pkg::wb_1;
				end
			end
			cache_pkg::wb_1: begin
				arr_enable = 1'b1;
				arr_offset = 3'd2;
				use_victim = 1'b1;
				mem_offset = 3'd2;
				mem_wr = mem_grant;
				next_state = cache_pkg::wb_2;
			end
			cache_pkg::wb_2: begin
				arr_enable = 1'b1;
				arr_offset = 3'd4;
				use_victim = 1'b1;
				mem_offset = 3'd4;
				mem_wr = mem_grant;
				next_state = cache_pkg::wb_3;
			end
			cache_pkg::wb_3: begin
				arr_enable = 1'b1;
				arr_offset = 3'd6;
				use_victim = 1'b1;
				mem_offset = 3'd6;
				mem_wr = mem_grant;
				next_state = cache_pkg::req_0;
			end
			cache_pkg::req_0: begin
				mem_rd = mem_grant;
				if (mem_grant) begin
					next_state = cache_pkg::req_1;
				end
			end
			cache_pkg::req_1: begin
				mem_rd = mem_grant;
				mem_offset = 3'd2;
				next_state = cache_pkg::req_2_fill_0;
			end
			cache_pkg::req_2_fill_0: begin
				mem_rd = mem_grant;
				mem_offset = 3'd4;
				arr_enable = 1'b1;
				arr_write = 1'b1;
				arr_offset = 3'd0;	// Word 0 arrives now
				arr_wdata = mem_rdata;
				next_state = cache_pkg::req_3_fill_1;
			end
			cache_pkg::req_3_fill_1: begin
				mem_rd = mem_grant;
				mem_offset = 3'd6;
				arr_enable = 1'b1;
				arr_write = 1'b1;
				arr_offset = 3'd2;
				arr_wdata = mem_rdata;
				next_state = cache_pkg::fill_2;
			end
			cache_pkg::fill_2: begin
				arr_enable = 1'b1;
				arr_write = 1'b1;
				arr_offset = 3'd4;
				arr_wdata = mem_rdata;
				next_state = cache_pkg::fill_3;
			end
			cache_pkg::fill_3: begin
				arr_enable = 1'b1;
				arr_write = 1'b1;
				arr_offset = 3'd6;
				arr_wdata = mem_rdata;
				// Retry the original access, which now hits
				next_state = req_write ? cache_pkg::comp_write : cache_pkg::comp_read;
			end
			cache_pkg::finish: begin
				done = 1'b1;
				next_state = cache_pkg::idle;
			end
			default: begin
				err = 1'b1;	// Illegal state
				next_state = cache_pkg::idle;
			end
		endcase
	end

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic req_0,
	input  logic req_1,
	output logic grant_0,
	output logic grant_1,
	input  logic rd_0,
	input  logic wr_0,
	input  cache_pkg::addr_t addr_0,
	input  cache_pkg::word_t wdata_0,
	input  logic rd_1,
	input  logic wr_1,
	input  cache_pkg::addr_t addr_1,
	input  cache_pkg::word_t wdata_1,
	output logic mem_rd,
	output logic mem_wr,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_wdata
);

	logic [cache_pkg::num_ports-1:0] req_vec;
	logic [cache_pkg::num_ports-1:0] grant_vec;
	logic busy;
	logic owner;
	logic last_served;
	logic pick;

	assign req_vec = {req_1, req_0};

	// Alternate on a tie, otherwise take whoever asks
	assign pick = (&req_vec) ? !last_served : req_vec[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			owner <= 1'b0;
			last_served <= 1'b1;	// Port 0 wins the first tie
		end else if (!(busy && req_vec[owner])) begin
			if (busy) begin
				last_served <= owner;	// Transfer finished
			end
			busy <= |req_vec;
			if (|req_vec) begin
				owner <= pick;
			end
		end
	end

	assign grant_vec[0] = busy && !owner;
	assign grant_vec[1] = busy && owner;
	assign grant_0 = grant_vec[0];
	assign grant_1 = grant_vec[1];

	assign mem_rd = (grant_0 && rd_0) || (grant_1 && rd_1);
	assign mem_wr = (grant_0 && wr_0) || (grant_1 && wr_1);
	assign mem_addr = owner ? addr_1 : addr_0;
	assign mem_wdata = owner ? wdata_1 : wdata_0;

endmodule

//--- logic/banked_memory.sv
`timescale 1ns/1ns

module banked_memory (
	input  logic clk,
	input  logic reset,
	input  logic rd,
	input  logic wr,
	input  cache_pkg::addr_t addr,
	input  cache_pkg::word_t wdata,
	output cache_pkg::word_t rdata
);

	cache_pkg::word_t banks [cache_pkg::num_banks][cache_pkg::bank_rows];
	logic [1:0] bank;
	logic [$clog2(cache_pkg::bank_rows)-1:0] row;
	logic [cache_pkg::mem_latency-1:0] pipe_valid;
	logic [1:0] pipe_bank [cache_pkg::mem_latency];
	logic [$clog2(cache_pkg::bank_rows)-1:0] pipe_row [cache_pkg::mem_latency];

	assign bank = addr[2:1];	// Adjacent words in adjacent banks
	assign row = addr[15:3];

	initial begin
		for (int b = 0; b < cache_pkg::num_banks; b++) begin
			for (int r = 0; r < cache_pkg::bank_rows; r++) begin
				banks[b][r] = '0;
			end
		end
	end

	always @(posedge clk) begin
		if (wr) begin
			banks[bank][row] <= wdata;
		end
	end

	// Read pipeline takes one new read per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[cache_pkg::mem_latency-2:0], rd};
		end
	end

	always_ff @(posedge clk) begin
		pipe_bank[0] <= bank;
		pipe_row[0] <= row;
		for (int i = 1; i < cache_pkg::mem_latency; i++) begin
			pipe_bank[i] <= pipe_bank[i-1];
			pipe_row[i] <= pipe_row[i-1];
		end
	end

	// Last stage selects the bank word
	assign rdata = pipe_valid[cache_pkg::mem_latency-1] ?
		banks[pipe_bank[cache_pkg::mem_latency-1]][pipe_row[cache_pkg::mem_latency-1]] : '0;

endmodule

//--- logic/cache_subsystem.sv
`timescale 1ns/1ns

module cache_subsystem (
	input  logic clk,
	input  logic reset,
	input  logic rd_0,
	input  logic wr_0,
	input  cache_pkg::addr_t addr_0,
	input  cache_pkg::word_t wdata_0,
	output cache_pkg::word_t rdata_0,
	output logic done_0,
	output logic stall_0,
	output logic err_0,
	input  logic rd_1,
	input  logic wr_1,
	input  cache_pkg::addr_t addr_1,
	input  cache_pkg::word_t wdata_1,
	output cache_pkg::word_t rdata_1,
	output logic done_1,
	output logic stall_1,
	output logic err_1
);

	// Controller to array
	logic arr_enable_0, arr_comp_0, arr_write_0, arr_hit_0, arr_valid_0, arr_dirty_0;
	logic arr_enable_1, arr_comp_1, arr_write_1, arr_hit_1, arr_valid_1, arr_dirty_1;
	cache_pkg::index_t arr_index_0, arr_index_1;
	cache_pkg::tag_t arr_tag_0, arr_tag_1, arr_victim_tag_0, arr_victim_tag_1;
	cache_pkg::offset_t arr_offset_0, arr_offset_1;
	cache_pkg::word_t arr_wdata_0, arr_wdata_1, arr_rdata_0, arr_rdata_1;

	// Controller to arbiter, arbiter to memory
	logic mem_req_0, mem_grant_0, mem_rd_0, mem_wr_0;
	logic mem_req_1, mem_grant_1, mem_rd_1, mem_wr_1;
	cache_pkg::addr_t mem_addr_0, mem_addr_1, mem_addr;
	cache_pkg::word_t mem_wdata_0, mem_wdata_1, mem_wdata, mem_rdata;
	logic mem_rd, mem_wr;

	cache_controller u_ctrl_0 (
		.clk(clk), .reset(reset), .rd(rd_0), .wr(wr_0), .addr(addr_0), .wdata(wdata_0),
		.rdata(rdata_0), .done(done_0), .stall(stall_0), .err(err_0),
		.arr_enable(arr_enable_0), .arr_comp(arr_comp_0), .arr_write(arr_write_0),
		.arr_index(arr_index_0), .arr_tag(arr_tag_0), .arr_offset(arr_offset_0),
		.arr_wdata(arr_wdata_0), .arr_hit(arr_hit_0), .arr_valid(arr_valid_0),
		.arr_dirty(arr_dirty_0), .arr_victim_tag(arr_victim_tag_0), .arr_rdata(arr_rdata_0),
		.mem_req(mem_req_0), .mem_grant(mem_grant_0), .mem_rd(mem_rd_0), .mem_wr(mem_wr_0),
		.mem_addr(mem_addr_0), .mem_wdata(mem_wdata_0), .mem_rdata(mem_rdata));

	cache_array u_array_0 (
		.clk(clk), .reset(reset), .enable(arr_enable_0), .comp(arr_comp_0),
		.write(arr_write_0), .index(arr_index_0), .tag(arr_tag_0), .offset(arr_offset_0),
		.wdata(arr_wdata_0), .hit(arr_hit_0), .valid(arr_valid_0), .dirty(arr_dirty_0),
		.victim_tag(arr_victim_tag_0), .rdata(arr_rdata_0));

	cache_controller u_ctrl_1 (
		.clk(clk), .reset(reset), .rd(rd_1), .wr(wr_1), .addr(addr_1), .wdata(wdata_1),
		.rdata(rdata_1), .done(done_1), .stall(stall_1), .err(err_1),
		.arr_enable(arr_enable_1), .arr_comp(arr_comp_1), .arr_write(arr_write_1),
		.arr_index(arr_index_1), .arr_tag(arr_tag_1), .arr_offset(arr_offset_1),
		.arr_wdata(arr_wdata_1), .arr_hit(arr_hit_1), .arr_valid(arr_valid_1),
		.arr_dirty(arr_dirty_1), .arr_victim_tag(arr_victim_tag_1), .arr_rdata(arr_rdata_1),
		.mem_req(mem_req_1), .mem_grant(mem_grant_1), .mem_rd(mem_rd_1), .mem_wr(mem_wr_1),
		.mem_addr(mem_addr_1), .mem_wdata(mem_wdata_1), .mem_rdata(mem_rdata));

	cache_array u_array_1 (
		.clk(clk), .reset(reset), .enable(arr_enable_1), .comp(arr_comp_1),
		.write(arr_write_1), .index(arr_index_1), .tag(arr_tag_1), .offset(arr_offset_1),
		.wdata(arr_wdata_1), .hit(arr_hit_1), .valid(arr_valid_1), .dirty(arr_dirty_1),
		.victim_tag(arr_victim_tag_1), .rdata(arr_rdata_1));

	mem_arbiter u_arbiter (
		.clk(clk), .reset(reset), .req_0(mem_req_0), .req_1(mem_req_1),
		.grant_0(mem_grant_0), .grant_1(mem_grant_1),
		.rd_0(mem_rd_0), .wr_0(mem_wr_0), .addr_0(mem_addr_0), .wdata_0(mem_wdata_0),
		.rd_1(mem_rd_1), .wr_1(mem_wr_1), .addr_1(mem_addr_1), .wdata_1(mem_wdata_1),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata));

	// Read data goes to both controllers
	banked_memory u_memory (
		.clk(clk), .reset(reset), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata));

endmodule

//--- tests/cache_checker.sv
`timescale 1ns/1ns

module cache_checker (
	input  logic clk,
	input  logic reset,
	input  logic [1:0] expect_fast,
	input  logic rd_0,
	input  logic wr_0,
	input  cache_pkg::addr_t addr_0,
	input  cache_pkg::word_t wdata_0,
	input  cache_pkg::word_t rdata_0,
	input  logic done_0,
	input  logic stall_0,
	input  logic err_0,
	input  logic rd_1,
	input  logic wr_1,
	input  cache_pkg::addr_t addr_1,
	input  cache_pkg::word_t wdata_1,
	input  cache_pkg::word_t rdata_1,
	input  logic done_1,
	input  logic stall_1,
	input  logic err_1,
	output int error_count
);

	cache_pkg::word_t shadow [cache_pkg::mem_words];	// One entry per memory word
	logic pending [cache_pkg::num_ports];
	logic pend_write [cache_pkg::num_ports];
	logic pend_fast [cache_pkg::num_ports];
	cache_pkg::addr_t pend_addr [cache_pkg::num_ports];
	cache_pkg::word_t pend_wdata [cache_pkg::num_ports];
	int latency [cache_pkg::num_ports];

	initial begin
		error_count = 0;
		for (int i = 0; i < cache_pkg::mem_words; i++) begin
			shadow[i] = '0;
		end
		for (int p = 0; p < cache_pkg::num_ports; p++) begin
			pending[p] = 1'b0;
			latency[p] = 0;
		end
	end

	// Last word written, or zero for an untouched address
	function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
		return shadow[a[15:1]];
	endfunction

	task automatic watch_port(input int p, input logic rd, input logic wr,
			input cache_pkg::addr_t addr, input cache_pkg::word_t wdata,
			input cache_pkg::word_t rdata, input logic done, input logic stall,
			input logic err);
		if (err) begin
			$display("error at %0t ns: port %0d raised err", $time, p);
			error_count++;
		end
		if (stall !== pending[p]) begin
			$display("error at %0t ns: port %0d stall is %b, busy is %b", $time, p,
				stall, pending[p]);
			error_count++;
		end
		if (pending[p]) begin
			latency[p]++;
			if (done) begin
				pending[p] = 1'b0;
				if (pend_write[p]) begin
					shadow[pend_addr[p][15:1]] = pend_wdata[p];
				end else if (rdata !== expected_word(pend_addr[p])) begin
					$display("error at %0t ns: port %0d addr %h expected %h actual %h", $time,
						p, pend_addr[p], expected_word(pend_addr[p]), rdata);
					error_count++;
				end
				if (pend_fast[p] && latency[p] != 2) begin
					$display("error at %0t ns: port %0d hit took %0d cycles, expected 2",
						$time, p, latency[p]);
					error_count++;
				end
			end
		end else if (done) begin
			$display("error at %0t ns: port %0d gave done with no request", $time, p);
			error_count++;
		end else if (!stall && (rd ^ wr)) begin
			pending[p] = 1'b1;	// Accepted at this edge
			pend_write[p] = wr;
			pend_addr[p] = addr;
			pend_wdata[p] = wdata;
			pend_fast[p] = expect_fast[p];
			latency[p] = 0;
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			watch_port(0, rd_0, wr_0, addr_0, wdata_0, rdata_0, done_0, stall_0, err_0);
			watch_port(1, rd_1, wr_1, addr_1, wdata_1, rdata_1, done_1, stall_1, err_1);
		end
	end

endmodule

//--- tests/tb_cache_subsystem.sv
`timescale 1ns/1ns

module tb_cache_subsystem;

	localparam int num_random = 300;	// Random operations per port
	localparam int timeout_cycles = 500;

	logic clk;
	logic reset;
	logic rd_0, wr_0, done_0, stall_0, err_0;
	logic rd_1, wr_1, done_1, stall_1, err_1;
	cache_pkg::addr_t addr_0, addr_1;
	cache_pkg::word_t wdata_0, wdata_1, rdata_0, rdata_1;
	logic [1:0] expect_fast;
	int checker_errors;
	int timeouts;
	logic abort;
	logic rand_write [2][num_random];
	cache_pkg::addr_t rand_addr [2][num_random];
	cache_pkg::word_t rand_data [2][num_random];

	cache_subsystem u_dut (
		.clk(clk), .reset(reset),
		.rd_0(rd_0), .wr_0(wr_0), .addr_0(addr_0), .wdata_0(wdata_0),
		.rdata_0(rdata_0), .done_0(done_0), .stall_0(stall_0), .err_0(err_0),
		.rd_1(rd_1), .wr_1(wr_1), .addr_1(addr_1), .wdata_1(wdata_1),
		.rdata_1(rdata_1), .done_1(done_1), .stall_1(stall_1), .err_1(err_1));

	cache_checker u_checker (
		.clk(clk), .reset(reset), .expect_fast(expect_fast),
		.rd_0(rd_0), .wr_0(wr_0), .addr_0(addr_0), .wdata_0(wdata_0),
		.rdata_0(rdata_0), .done_0(done_0), .stall_0(stall_0), .err_0(err_0),
		.rd_1(rd_1), .wr_1(wr_1), .addr_1(addr_1), .wdata_1(wdata_1),
		.rdata_1(rdata_1), .done_1(done_1), .stall_1(stall_1), .err_1(err_1),
		.error_count(checker_errors));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	task automatic drive_port(input int p, input logic rd, input logic wr,
			input cache_pkg::addr_t a, input cache_pkg::word_t d);
		if (p == 0) begin
			rd_0 = rd;
			wr_0 = wr;
			addr_0 = a;
			wdata_0 = d;
		end else begin
			rd_1 = rd;
			wr_1 = wr;
			addr_1 = a;
			wdata_1 = d;
		end
	endtask

	function automatic logic stall_level(input int p);
		return (p == 0) ? stall_0 : stall_1;
	endfunction

	function automatic logic done_level(input int p);
		return (p == 0) ? done_0 : done_1;
	endfunction

	task automatic report_timeout(input int p, input string what);
		$display("port %0d timed out at %0t ns waiting for %0s", p, $time, what);
		timeouts++;
		abort = 1'b1;	// Stop both ports
	endtask

	// One request on port p from idle wait to done
	task automatic access(input int p, input logic write, input cache_pkg::addr_t a,
			input cache_pkg::word_t d, input logic fast);
		int count;
		count = 0;
		if (abort) return;
		while (stall_level(p) && count < timeout_cycles) begin
			@(posedge clk);
			#5;
			count++;
		end
		if (stall_level(p)) begin
			report_timeout(p, "stall to fall");
			return;
		end
		drive_port(p, !write, write, a, d);
		expect_fast[p] = fast;
		@(posedge clk);	// Accepting edge
		#5;
		drive_port(p, 1'b0, 1'b0, a, d);
		expect_fast[p] = 1'b0;
		count = 0;
		while (!done_level(p) && count < timeout_cycles) begin
			@(posedge clk);
			#5;
			count++;
		end
		if (!done_level(p)) report_timeout(p, "done");
	endtask

	// Small pool per core half makes lines collide often
	function automatic cache_pkg::addr_t pool_addr(input int p);
		cache_pkg::addr_t a;
		a = '0;
		a[15] = p[0];
		a[9:8] = 2'($urandom % 3);
		a[4:3] = 2'($urandom % 4);
		a[2:1] = 2'($urandom % 4);
		return a;
	endfunction

	initial begin
		void'($urandom(69));
		reset = 1'b1;
		timeouts = 0;
		abort = 1'b0;
		expect_fast = 2'b00;
		drive_port(0, 1'b0, 1'b0, '0, '0);
		drive_port(1, 1'b0, 1'b0, '0, '0);
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < num_random; i++) begin
				rand_write[p][i] = 1'($urandom % 2);
				rand_addr[p][i] = pool_addr(p);
				rand_data[p][i] = cache_pkg::word_t'($urandom);
			end
		end
		repeat (16) @(posedge clk);
		#5;
		reset = 1'b0;

		access(0, 1'b0, 16'h0010, '0, 1'b0);	// Clean miss needs a fill only
		access(1, 1'b0, 16'h8010, '0, 1'b0);
		access(0, 1'b1, 16'h0020, 16'h1234, 1'b0);
		access(0, 1'b0, 16'h0020, '0, 1'b1);	// Hit gives done two edges later
		access(0, 1'b1, 16'h0040, 16'haaaa, 1'b0);
		access(0, 1'b1, 16'h0140, 16'h5555, 1'b0);	// Same index forces a write-back
		access(0, 1'b0, 16'h0040, '0, 1'b0);
		access(0, 1'b0, 16'h0140, '0, 1'b0);

		// Simultaneous misses through the arbiter
		fork
			access(0, 1'b0, 16'h0300, '0, 1'b0);
			access(1, 1'b0, 16'h8300, '0, 1'b0);
		join
		fork
			access(0, 1'b1, 16'h0508, 16'h0f0f, 1'b0);
			access(1, 1'b1, 16'h8508, 16'hf0f0, 1'b0);
		join
		fork
			access(0, 1'b0, 16'h0508, '0, 1'b1);
			access(1, 1'b0, 16'h8508, '0, 1'b1);
		join

		fork
			for (int i = 0; i < num_random; i++) begin
				access(0, rand_write[0][i], rand_addr[0][i], rand_data[0][i], 1'b0);
			end
			for (int i = 0; i < num_random; i++) begin
				access(1, rand_write[1][i], rand_addr[1][i], rand_data[1][i], 1'b0);
			end
		join

		repeat (4) @(posedge clk);
		$display("errors %0d, timeouts %0d", checker_errors, timeouts);
		if (checker_errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
logic/cache_pkg.sv
logic/cache_array.sv
logic/cache_controller.sv
logic/mem_arbiter.sv
logic/banked_memory.sv
logic/cache_subsystem.sv
tests/cache_checker.sv
tests/tb_cache_subsystem.sv
